//--- hdl/host_domain_pkg.sv
//--------------------
// Address map, sizes and register offsets of the host memory domain.
// L2_BASE and CFG_BASE must be aligned to the size of their window.
// NB_L2_BANKS and L2_BANK_WORDS must be powers of two.
//--------------------
`default_nettype none

package host_domain_pkg;

  // Bus widths
  localparam int unsigned DATA_W = 32;
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned STRB_W = 4;

  // L2 scratchpad, word interleaved over the banks
  localparam int unsigned NB_L2_BANKS   = 8;
  localparam int unsigned L2_BANK_WORDS = 256;
  localparam int unsigned L2_BANK_SEL_W = $clog2(NB_L2_BANKS);
  localparam int unsigned L2_WORD_IDX_W = $clog2(L2_BANK_WORDS);
  localparam logic [ADDR_W-1:0] L2_BASE = 32'h1C00_0000;
  localparam logic [ADDR_W-1:0] L2_SIZE = ADDR_W'(NB_L2_BANKS * L2_BANK_WORDS * STRB_W);

  // Configuration window
  localparam logic [ADDR_W-1:0] CFG_BASE = 32'h1A10_0000;
  localparam logic [ADDR_W-1:0] CFG_SIZE = 32'h0000_1000;
  localparam int unsigned       CFG_OFS_W = $clog2(CFG_SIZE);

  localparam logic [CFG_OFS_W-1:0] CFG_ID_OFS      = 'h0;
  localparam logic [CFG_OFS_W-1:0] CFG_SCRATCH_OFS = 'h4;
  localparam logic [CFG_OFS_W-1:0] CFG_RDCNT_OFS   = 'h8;
  localparam logic [CFG_OFS_W-1:0] CFG_WRCNT_OFS   = 'hC;

  localparam logic [DATA_W-1:0] CFG_ID_VALUE = 32'h4844_0001;

  // Queue depths
  localparam int unsigned ORDER_DEPTH = 4;
  localparam int unsigned RSP_DEPTH   = 2;

  // Branch that serves a request
  typedef enum logic [1:0] {
    TGT_L2,
    TGT_CFG,
    TGT_ERR
  } target_e;

endpackage

`default_nettype wire

//--- hdl/rsp_fifo.sv
//--------------------
// Synchronous FIFO with show-ahead output, any DEPTH >= 1.
// A push while full or a pop while empty is dropped.
// Entries carry no reset, only pointers and occupancy do.
//--------------------
`timescale 1ns/100ps
`default_nettype none

module rsp_fifo #(
  parameter int unsigned DEPTH = 2,
  parameter int unsigned WIDTH = 32
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             push_i,
  input  logic [WIDTH-1:0] push_data_i,
  input  logic             pop_i,
  output logic             full_o,
  output logic             valid_o,
  output logic [WIDTH-1:0] data_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push_en;
  logic             pop_en;

  // Pointer increment with wrap for non power of two depths
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign valid_o = (count_q != '0);
  assign data_o  = mem_q[rd_ptr_q];
  assign push_en = push_i && !full_o;
  assign pop_en  = pop_i && valid_o;

  always_ff @(posedge clk_i) begin
    if (push_en) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_en) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (pop_en) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      if (push_en && !pop_en) begin
        count_q <= count_q + 1'b1;
      end else if (pop_en && !push_en) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/req_decoder.sv
//--------------------
// Steers host requests to the L2 or configuration branch by address.
// Purely combinational, no cycle is added.
// A request only goes when the order queue has room and the branch is ready.
// Unmapped addresses need only the order queue.
//--------------------
`timescale 1ns/100ps
`default_nettype none

module req_decoder (
  input  logic                               req_valid_i,
  input  logic [host_domain_pkg::ADDR_W-1:0] req_addr_i,
  output logic                               req_ready_o,
  input  logic                               l2_ready_i,
  input  logic                               cfg_ready_i,
  input  logic                               ord_full_i,
  output logic                               l2_valid_o,
  output logic                               cfg_valid_o,
  output logic                               ord_push_o,
  output host_domain_pkg::target_e           ord_tgt_o
);

  import host_domain_pkg::*;

  target_e tgt;
  logic    in_l2;
  logic    in_cfg;
  logic    branch_ready;

  assign in_l2  = (req_addr_i >= L2_BASE) && (req_addr_i < L2_BASE + L2_SIZE);
  assign in_cfg = (req_addr_i >= CFG_BASE) && (req_addr_i < CFG_BASE + CFG_SIZE);

  always_comb begin
    if (in_l2) begin
      tgt = TGT_L2;
    end else if (in_cfg) begin
      tgt = TGT_CFG;
    end else begin
      tgt = TGT_ERR;
    end
  end

  always_comb begin
    case (tgt)
      TGT_L2:  branch_ready = l2_ready_i;
      TGT_CFG: branch_ready = cfg_ready_i;
      default: branch_ready = 1'b1;
    endcase
  end

  assign req_ready_o = !ord_full_i && branch_ready;

  // Branch valid only when the queue can take the target too
  assign l2_valid_o  = req_valid_i && !ord_full_i && (tgt == TGT_L2);
  assign cfg_valid_o = req_valid_i && !ord_full_i && (tgt == TGT_CFG);

  assign ord_push_o = req_valid_i && req_ready_o;
  assign ord_tgt_o  = tgt;

endmodule

`default_nettype wire

//--- hdl/l2_bank_array.sv
//--------------------
// Word interleaved L2 scratchpad, one bank per low word address bit pattern.
// Reads are combinational, the response is queued in the accept cycle.
// Contents are undefined after reset. Writes answer with zero data.
//--------------------
`timescale 1ns/100ps
`default_nettype none

module l2_bank_array (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  logic                               l2_valid_i,
  input  logic                               req_we_i,
  input  logic [host_domain_pkg::ADDR_W-1:0] req_addr_i,
  input  logic [host_domain_pkg::DATA_W-1:0] req_wdata_i,
  input  logic [host_domain_pkg::STRB_W-1:0] req_strb_i,
  input  logic                               l2_pop_i,
  output logic                               l2_ready_o,
  output logic                               l2_rsp_valid_o,
  output logic [host_domain_pkg::DATA_W-1:0] l2_rsp_rdata_o,
  output logic                               l2_rd_evt_o,
  output logic                               l2_wr_evt_o
);

  import host_domain_pkg::*;

  localparam int unsigned BANK_LSB = $clog2(STRB_W);
  localparam int unsigned WORD_LSB = BANK_LSB + L2_BANK_SEL_W;

  logic                     accept;
  logic                     fifo_full;
  logic [L2_BANK_SEL_W-1:0] bank_sel;
  logic [L2_WORD_IDX_W-1:0] word_idx;
  logic [DATA_W-1:0]        bank_rdata [NB_L2_BANKS];
  logic [DATA_W-1:0]        rsp_rdata;

  assign accept   = l2_valid_i && l2_ready_o;
  assign bank_sel = req_addr_i[BANK_LSB +: L2_BANK_SEL_W];
  assign word_idx = req_addr_i[WORD_LSB +: L2_WORD_IDX_W];

  for (genvar b = 0; b < NB_L2_BANKS; b++) begin : gen_bank
    logic [DATA_W-1:0] mem_q [L2_BANK_WORDS];
    logic              bank_we;

    assign bank_we       = accept && req_we_i && (bank_sel == L2_BANK_SEL_W'(b));
    assign bank_rdata[b] = mem_q[word_idx];

    // Byte lanes follow the strobe
    always_ff @(posedge clk_i) begin
      for (int i = 0; i < STRB_W; i++) begin
        if (bank_we && req_strb_i[i]) begin
          mem_q[word_idx][8*i +: 8] <= req_wdata_i[8*i +: 8];
        end
      end
    end
  end

  assign rsp_rdata = req_we_i ? '0 : bank_rdata[bank_sel];

  rsp_fifo #(
    .DEPTH ( RSP_DEPTH ),
    .WIDTH ( DATA_W    )
  ) i_rsp_fifo (
    .clk_i       ( clk_i          ),
    .rst_i       ( rst_i          ),
    .push_i      ( accept         ),
    .push_data_i ( rsp_rdata      ),
    .pop_i       ( l2_pop_i       ),
    .full_o      ( fifo_full      ),
    .valid_o     ( l2_rsp_valid_o ),
    .data_o      ( l2_rsp_rdata_o )
  );

  assign l2_ready_o = !fifo_full;

  // Access events for the counters in the configuration block
  assign l2_rd_evt_o = accept && !req_we_i;
  assign l2_wr_evt_o = accept && req_we_i;

endmodule

`default_nettype wire

//--- hdl/cfg_regs.sv
//--------------------
// ID, scratch and L2 read/write event counters.
// Only the four word offsets are mapped, anything else answers with err.
// Writes to the ID are dropped, writes to a counter clear it.
//--------------------
`timescale 1ns/100ps
`default_nettype none

module cfg_regs (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  logic                               cfg_valid_i,
  input  logic                               req_we_i,
  input  logic [host_domain_pkg::ADDR_W-1:0] req_addr_i,
  input  logic [host_domain_pkg::DATA_W-1:0] req_wdata_i,
  input  logic                               l2_rd_evt_i,
  input  logic                               l2_wr_evt_i,
  input  logic                               cfg_pop_i,
  output logic                               cfg_ready_o,
  output logic                               cfg_rsp_valid_o,
  output logic [host_domain_pkg::DATA_W-1:0] cfg_rsp_rdata_o,
  output logic                               cfg_rsp_err_o
);

  import host_domain_pkg::*;

  logic                 accept;
  logic                 fifo_full;
  logic [CFG_OFS_W-1:0] ofs;
  logic [DATA_W-1:0]    scratch_q;
  logic [DATA_W-1:0]    rd_cnt_q;
  logic [DATA_W-1:0]    wr_cnt_q;
  logic [DATA_W-1:0]    rsp_rdata;
  logic                 rsp_err;

  assign accept = cfg_valid_i && cfg_ready_o;
  assign ofs    = req_addr_i[CFG_OFS_W-1:0];

  always_comb begin
    rsp_rdata = '0;
    rsp_err   = 1'b0;
    case (ofs)
      CFG_ID_OFS:      rsp_rdata = req_we_i ? '0 : CFG_ID_VALUE;
      CFG_SCRATCH_OFS: rsp_rdata = req_we_i ? '0 : scratch_q;
      CFG_RDCNT_OFS:   rsp_rdata = req_we_i ? '0 : rd_cnt_q;
      CFG_WRCNT_OFS:   rsp_rdata = req_we_i ? '0 : wr_cnt_q;
      default:         rsp_err   = 1'b1;
    endcase
  end

  // A counter clear and an L2 event never share a cycle
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      scratch_q <= '0;
      rd_cnt_q  <= '0;
      wr_cnt_q  <= '0;
    end else begin
      if (accept && req_we_i && ofs == CFG_SCRATCH_OFS) begin
        scratch_q <= req_wdata_i;
      end
      if (accept && req_we_i && ofs == CFG_RDCNT_OFS) begin
        rd_cnt_q <= '0;
      end else if (l2_rd_evt_i) begin
        rd_cnt_q <= rd_cnt_q + 1'b1;
      end
      if (accept && req_we_i && ofs == CFG_WRCNT_OFS) begin
        wr_cnt_q <= '0;
      end else if (l2_wr_evt_i) begin
        wr_cnt_q <= wr_cnt_q + 1'b1;
      end
    end
  end

  rsp_fifo #(
    .DEPTH ( RSP_DEPTH  ),
    .WIDTH ( DATA_W + 1 )
  ) i_rsp_fifo (
    .clk_i       ( clk_i                            ),
    .rst_i       ( rst_i                            ),
    .push_i      ( accept                           ),
    .push_data_i ( {rsp_err, rsp_rdata}             ),
    .pop_i       ( cfg_pop_i                        ),
    .full_o      ( fifo_full                        ),
    .valid_o     ( cfg_rsp_valid_o                  ),
    .data_o      ( {cfg_rsp_err_o, cfg_rsp_rdata_o} )
  );

  assign cfg_ready_o = !fifo_full;

endmodule

`default_nettype wire

//--- hdl/rsp_merger.sv
//--------------------
// Returns branch responses in request order using a queue of targets.
// Unmapped requests are answered here with err and zero data.
// Combinational between the queue head and the branch FIFOs.
//--------------------
`timescale 1ns/100ps
`default_nettype none

module rsp_merger (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  logic                               ord_push_i,
  input  host_domain_pkg::target_e           ord_tgt_i,
  input  logic                               l2_rsp_valid_i,
  input  logic [host_domain_pkg::DATA_W-1:0] l2_rsp_rdata_i,
  input  logic                               cfg_rsp_valid_i,
  input  logic [host_domain_pkg::DATA_W-1:0] cfg_rsp_rdata_i,
  input  logic                               cfg_rsp_err_i,
  input  logic                               rsp_ready_i,
  output logic                               ord_full_o,
  output logic                               l2_pop_o,
  output logic                               cfg_pop_o,
  output logic                               rsp_valid_o,
  output logic [host_domain_pkg::DATA_W-1:0] rsp_rdata_o,
  output logic                               rsp_err_o
);

  import host_domain_pkg::*;

  localparam int unsigned TGT_W = $bits(target_e);

  logic             head_valid;
  logic [TGT_W-1:0] head_data;
  target_e          head_tgt;
  logic             rsp_fire;

  rsp_fifo #(
    .DEPTH ( ORDER_DEPTH ),
    .WIDTH ( TGT_W       )
  ) i_order_queue (
    .clk_i       ( clk_i      ),
    .rst_i       ( rst_i      ),
    .push_i      ( ord_push_i ),
    .push_data_i ( ord_tgt_i  ),
    .pop_i       ( rsp_fire   ),
    .full_o      ( ord_full_o ),
    .valid_o     ( head_valid ),
    .data_o      ( head_data  )
  );

  assign head_tgt = target_e'(head_data);

  always_comb begin
    rsp_valid_o = 1'b0;
    rsp_rdata_o = '0;
    rsp_err_o   = 1'b0;
    if (head_valid) begin
      case (head_tgt)
        TGT_L2: begin
          rsp_valid_o = l2_rsp_valid_i;
          rsp_rdata_o = l2_rsp_rdata_i;
        end
        TGT_CFG: begin
          rsp_valid_o = cfg_rsp_valid_i;
          rsp_rdata_o = cfg_rsp_rdata_i;
          rsp_err_o   = cfg_rsp_err_i;
        end
        default: begin
          rsp_valid_o = 1'b1;
          rsp_err_o   = 1'b1;
        end
      endcase
    end
  end

  assign rsp_fire  = rsp_valid_o && rsp_ready_i;
  assign l2_pop_o  = rsp_fire && (head_tgt == TGT_L2);
  assign cfg_pop_o = rsp_fire && (head_tgt == TGT_CFG);

endmodule

`default_nettype wire

//--- hdl/host_domain.sv
//--------------------
// Host memory domain with one valid/ready request port.
// L2 at L2_BASE, registers at CFG_BASE, other addresses answer with err.
// Responses come back in request order, at least one cycle after accept.
// Up to ORDER_DEPTH requests can be in flight.
//--------------------
`timescale 1ns/100ps
`default_nettype none

module host_domain (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  logic                               req_valid_i,
  output logic                               req_ready_o,
  input  logic                               req_we_i,
  input  logic [host_domain_pkg::ADDR_W-1:0] req_addr_i,
  input  logic [host_domain_pkg::DATA_W-1:0] req_wdata_i,
  input  logic [host_domain_pkg::STRB_W-1:0] req_strb_i,
  output logic                               rsp_valid_o,
  input  logic                               rsp_ready_i,
  output logic [host_domain_pkg::DATA_W-1:0] rsp_rdata_o,
  output logic                               rsp_err_o
);

  import host_domain_pkg::*;

  logic              l2_valid;
  logic              l2_ready;
  logic              cfg_valid;
  logic              cfg_ready;
  logic              ord_push;
  target_e           ord_tgt;
  logic              ord_full;
  logic              l2_rsp_valid;
  logic [DATA_W-1:0] l2_rsp_rdata;
  logic              l2_pop;
  logic              cfg_rsp_valid;
  logic [DATA_W-1:0] cfg_rsp_rdata;
  logic              cfg_rsp_err;
  logic              cfg_pop;
  logic              l2_rd_evt;
  logic              l2_wr_evt;

  req_decoder i_req_decoder (
    .req_valid_i ( req_valid_i ),
    .req_addr_i  ( req_addr_i  ),
    .req_ready_o ( req_ready_o ),
    .l2_ready_i  ( l2_ready    ),
    .cfg_ready_i ( cfg_ready   ),
    .ord_full_i  ( ord_full    ),
    .l2_valid_o  ( l2_valid    ),
    .cfg_valid_o ( cfg_valid   ),
    .ord_push_o  ( ord_push    ),
    .ord_tgt_o   ( ord_tgt     )
  );

  l2_bank_array i_l2_bank_array (
    .clk_i          ( clk_i        ),
    .rst_i          ( rst_i        ),
    .l2_valid_i     ( l2_valid     ),
    .req_we_i       ( req_we_i     ),
    .req_addr_i     ( req_addr_i   ),
    .req_wdata_i    ( req_wdata_i  ),
    .req_strb_i     ( req_strb_i   ),
    .l2_pop_i       ( l2_pop       ),
    .l2_ready_o     ( l2_ready     ),
    .l2_rsp_valid_o ( l2_rsp_valid ),
    .l2_rsp_rdata_o ( l2_rsp_rdata ),
    .l2_rd_evt_o    ( l2_rd_evt    ),
    .l2_wr_evt_o    ( l2_wr_evt    )
  );

  cfg_regs i_cfg_regs (
    .clk_i           ( clk_i         ),
    .rst_i           ( rst_i         ),
    .cfg_valid_i     ( cfg_valid     ),
    .req_we_i        ( req_we_i      ),
    .req_addr_i      ( req_addr_i    ),
    .req_wdata_i     ( req_wdata_i   ),
    .l2_rd_evt_i     ( l2_rd_evt     ),
    .l2_wr_evt_i     ( l2_wr_evt     ),
    .cfg_pop_i       ( cfg_pop       ),
    .cfg_ready_o     ( cfg_ready     ),
    .cfg_rsp_valid_o ( cfg_rsp_valid ),
    .cfg_rsp_rdata_o ( cfg_rsp_rdata ),
    .cfg_rsp_err_o   ( cfg_rsp_err   )
  );

  rsp_merger i_rsp_merger (
    .clk_i           ( clk_i         ),
    .rst_i           ( rst_i         ),
    .ord_push_i      ( ord_push      ),
    .ord_tgt_i       ( ord_tgt       ),
    .l2_rsp_valid_i  ( l2_rsp_valid  ),
    .l2_rsp_rdata_i  ( l2_rsp_rdata  ),
    .cfg_rsp_valid_i ( cfg_rsp_valid ),
    .cfg_rsp_rdata_i ( cfg_rsp_rdata ),
    .cfg_rsp_err_i   ( cfg_rsp_err   ),
    .rsp_ready_i     ( rsp_ready_i   ),
    .ord_full_o      ( ord_full      ),
    .l2_pop_o        ( l2_pop        ),
    .cfg_pop_o       ( cfg_pop       ),
    .rsp_valid_o     ( rsp_valid_o   ),
    .rsp_rdata_o     ( rsp_rdata_o   ),
    .rsp_err_o       ( rsp_err_o     )
  );

endmodule

`default_nettype wire

//--- bench/host_domain_props.sv
//--------------------
// Response port properties of host_domain, attached by bind.
// The in flight count is rebuilt from the top level handshakes.
//--------------------
`timescale 1ns/100ps
`default_nettype none

module host_domain_props (
  input logic                               clk_i,
  input logic                               rst_i,
  input logic                               req_valid_i,
  input logic                               req_ready_i,
  input logic                               rsp_valid_i,
  input logic                               rsp_ready_i,
  input logic [host_domain_pkg::DATA_W-1:0] rsp_rdata_i,
  input logic                               rsp_err_i
);

  int unsigned err_cnt = 0;
  int unsigned in_flight_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      in_flight_q <= 0;
    end else begin
      in_flight_q <= in_flight_q + 32'(req_valid_i && req_ready_i)
                     - 32'(rsp_valid_i && rsp_ready_i);
    end
  end

  rsp_stable_a : assert property (@(posedge clk_i) disable iff (rst_i)
    rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_rdata_i) && $stable(rsp_err_i))
  else begin
    err_cnt++;
    $error("Response payload changed while stalled");
  end

  rst_idle_a : assert property (@(posedge clk_i) rst_i |=> !rsp_valid_i)
  else begin
    err_cnt++;
    $error("Response valid in the cycle after reset");
  end

  // Nothing in flight means the request of this cycle cannot be answered yet
  no_same_cycle_a : assert property (@(posedge clk_i) disable iff (rst_i)
    (in_flight_q == 0) |-> !rsp_valid_i)
  else begin
    err_cnt++;
    $error("Response in the same cycle as its request");
  end

endmodule

bind host_domain host_domain_props i_props (
  .clk_i       ( clk_i       ),
  .rst_i       ( rst_i       ),
  .req_valid_i ( req_valid_i ),
  .req_ready_i ( req_ready_o ),
  .rsp_valid_i ( rsp_valid_o ),
  .rsp_ready_i ( rsp_ready_i ),
  .rsp_rdata_i ( rsp_rdata_o ),
  .rsp_err_i   ( rsp_err_o   )
);

`default_nettype wire

//--- bench/tb_host_domain.sv
//--------------------
// Testbench for host_domain against a shadow model of L2 and the registers.
// L2 is filled first, its contents are undefined after reset.
// Fixed seed, stops at the first mismatch or timeout.
//--------------------
`timescale 1ns/100ps
`default_nettype none

module tb_host_domain;

  import host_domain_pkg::*;

  localparam int unsigned CLK_PERIOD = 8;
  localparam int unsigned SETTLE     = 2;
  localparam int unsigned TIMEOUT    = 200;
  localparam int unsigned L2_WORDS   = NB_L2_BANKS * L2_BANK_WORDS;

  logic              clk_i;
  logic              rst_i;
  logic              req_valid_i;
  logic              req_ready_o;
  logic              req_we_i;
  logic [ADDR_W-1:0] req_addr_i;
  logic [DATA_W-1:0] req_wdata_i;
  logic [STRB_W-1:0] req_strb_i;
  logic              rsp_valid_o;
  logic              rsp_ready_i;
  logic [DATA_W-1:0] rsp_rdata_o;
  logic              rsp_err_o;

  // Shadow state and expected responses in request order
  logic [DATA_W-1:0] shadow_l2 [L2_WORDS];
  logic [DATA_W-1:0] shadow_scratch;
  logic [DATA_W-1:0] shadow_rd_cnt;
  logic [DATA_W-1:0] shadow_wr_cnt;
  logic [DATA_W-1:0] exp_rdata_q [$];
  logic              exp_err_q [$];
  string             exp_name_q [$];
  string             test_name;

  // Keeps rsp_ready_i low so responses stay pending
  logic              hold_rsp;

  host_domain i_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1);
  endtask

  function automatic logic [ADDR_W-1:0] l2_addr(input int unsigned idx);
    return L2_BASE + (ADDR_W'(idx) << 2);
  endfunction

  function automatic logic [ADDR_W-1:0] rand_l2_addr();
    return l2_addr($urandom_range(L2_WORDS - 1));
  endfunction

  // Outside both windows
  function automatic logic [ADDR_W-1:0] rand_err_addr();
    return 32'h2000_0000 | ($urandom & 32'h0FFF_FFFC);
  endfunction

  function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] addr);
    return {addr[15:0], addr[31:16]} ^ ~addr;
  endfunction

  // Expected response at acceptance, shadow state updated in request order
  task automatic predict(input logic we, input logic [ADDR_W-1:0] addr,
                         input logic [DATA_W-1:0] wdata, input logic [STRB_W-1:0] strb);
    logic [DATA_W-1:0] rdata;
    logic              err;
    logic [11:0]       ofs;
    int unsigned       idx;
    rdata = '0;
    err   = 1'b0;
    ofs   = addr[11:0];
    idx   = (addr - L2_BASE) >> 2;
    if (addr >= L2_BASE && addr < L2_BASE + L2_SIZE) begin
      if (we) begin
        for (int b = 0; b < STRB_W; b++) begin
          if (strb[b]) begin
            shadow_l2[idx][8*b +: 8] = wdata[8*b +: 8];
          end
        end
        shadow_wr_cnt = shadow_wr_cnt + 1;
      end else begin
        rdata = shadow_l2[idx];
        shadow_rd_cnt = shadow_rd_cnt + 1;
      end
    end else if (addr >= CFG_BASE && addr < CFG_BASE + CFG_SIZE) begin
      case (ofs)
        12'h000: rdata = we ? '0 : 32'h4844_0001;
        12'h004: begin
          rdata = we ? '0 : shadow_scratch;
          shadow_scratch = we ? wdata : shadow_scratch;
        end
        12'h008: begin
          rdata = we ? '0 : shadow_rd_cnt;
          shadow_rd_cnt = we ? '0 : shadow_rd_cnt;
        end
        12'h00C: begin
          rdata = we ? '0 : shadow_wr_cnt;
          shadow_wr_cnt = we ? '0 : shadow_wr_cnt;
        end
        default: err = 1'b1;
      endcase
    end else begin
      err = 1'b1;
    end
    exp_rdata_q.push_back(rdata);
    exp_err_q.push_back(err);
    exp_name_q.push_back(test_name);
  endtask

  task automatic send_req(input logic we, input logic [ADDR_W-1:0] addr,
                          input logic [DATA_W-1:0] wdata, input logic [STRB_W-1:0] strb);
    int unsigned waited;
    waited = 0;
    @(negedge clk_i);
    req_valid_i = 1'b1;
    req_we_i    = we;
    req_addr_i  = addr;
    req_wdata_i = wdata;
    req_strb_i  = strb;
    #(SETTLE);
    while (!req_ready_o) begin
      if (waited >= TIMEOUT) begin
        report_failure($sformatf("Timeout: request to %h was never accepted", addr));
      end
      @(negedge clk_i);
      #(SETTLE);
      waited++;
    end
    predict(we, addr, wdata, strb);
  endtask

  // Wait until every expected response has been seen
  task automatic wait_drained();
    int unsigned waited;
    waited = 0;
    while (exp_rdata_q.size() != 0) begin
      if (waited >= TIMEOUT) begin
        report_failure("Timeout: expected responses never arrived");
      end
      @(negedge clk_i);
      waited++;
    end
  endtask

  // Random stalls on rsp_ready_i, each response checked against the queue head
  task automatic check_responses();
    logic [DATA_W-1:0] exp_rdata;
    logic              exp_err;
    string             name;
    forever begin
      @(negedge clk_i);
      rsp_ready_i = ($urandom_range(7) > 2) && !hold_rsp;
      #(SETTLE);
      if (!rst_i && rsp_valid_o && rsp_ready_i) begin
        if (exp_rdata_q.size() == 0) begin
          report_failure("A response arrived with no request outstanding");
        end
        exp_rdata = exp_rdata_q.pop_front();
        exp_err   = exp_err_q.pop_front();
        name      = exp_name_q.pop_front();
        assert (rsp_rdata_o === exp_rdata && rsp_err_o === exp_err) else begin
          report_failure($sformatf(
            "CHECK FAILED %s: expected rdata %h err %b, actual rdata %h err %b",
            name, exp_rdata, exp_err, rsp_rdata_o, rsp_err_o));
        end
      end
    end
  endtask

  initial begin
    logic [ADDR_W-1:0] addr;
    void'($urandom(32'h612984bb));
    rst_i          = 1'b1;
    req_valid_i    = 1'b0;
    req_we_i       = 1'b0;
    req_addr_i     = '0;
    req_wdata_i    = '0;
    req_strb_i     = '0;
    rsp_ready_i    = 1'b0;
    hold_rsp       = 1'b0;
    shadow_scratch = '0;
    shadow_rd_cnt  = '0;
    shadow_wr_cnt  = '0;
    test_name      = "reset";
    fork
      check_responses();
    join_none
    repeat (2) @(negedge clk_i);
    rst_i = 1'b0;

    test_name = "l2_fill";
    for (int i = 0; i < L2_WORDS; i++) begin
      send_req(1'b1, l2_addr(i), fill_word(l2_addr(i)), 4'hF);
    end
    test_name = "l2_strobe";
    for (int i = 0; i < 300; i++) begin
      addr = rand_l2_addr();
      send_req(1'b1, addr, $urandom, STRB_W'($urandom_range(15)));
      send_req(1'b0, rand_l2_addr(), '0, '0);
      send_req(1'b0, addr, '0, '0);
    end

    test_name = "cfg_id";
    send_req(1'b0, CFG_BASE, '0, '0);
    send_req(1'b1, CFG_BASE, $urandom, 4'hF);
    send_req(1'b0, CFG_BASE, '0, '0);
    test_name = "cfg_scratch";
    for (int i = 0; i < 4; i++) begin
      send_req(1'b1, CFG_BASE + 32'h4, $urandom, 4'hF);
      send_req(1'b0, CFG_BASE + 32'h4, '0, '0);
    end

    test_name = "cnt_read";
    send_req(1'b0, CFG_BASE + 32'h8, '0, '0);
    send_req(1'b0, CFG_BASE + 32'hC, '0, '0);
    test_name = "cnt_clear";
    send_req(1'b1, CFG_BASE + 32'h8, $urandom, 4'hF);
    send_req(1'b1, CFG_BASE + 32'hC, $urandom, 4'hF);
    for (int i = 0; i < 12; i++) begin
      send_req(1'($urandom_range(1)), rand_l2_addr(), $urandom, 4'hF);
    end
    send_req(1'b0, CFG_BASE + 32'h8, '0, '0);
    send_req(1'b0, CFG_BASE + 32'hC, '0, '0);

    test_name = "err_resp";
    send_req(1'b0, L2_BASE - 32'h4, '0, '0);
    send_req(1'b1, L2_BASE + L2_SIZE, $urandom, 4'hF);
    send_req(1'b0, CFG_BASE - 32'h4, '0, '0);
    send_req(1'b1, CFG_BASE + CFG_SIZE, $urandom, 4'hF);
    send_req(1'b0, CFG_BASE + 32'h10, '0, '0);
    send_req(1'b1, CFG_BASE + 32'hFFC, $urandom, 4'hF);
    for (int i = 0; i < 20; i++) begin
      send_req(1'($urandom_range(1)), rand_err_addr(), $urandom, 4'hF);
    end

    // Back to back mix of all targets, undefined offsets included
    test_name = "mixed";
    for (int i = 0; i < 500; i++) begin
      case ($urandom_range(2))
        0: addr = rand_l2_addr();
        1: addr = CFG_BASE + (ADDR_W'($urandom_range(5)) << 2);
        default: addr = rand_err_addr();
      endcase
      send_req(1'($urandom_range(1)), addr, $urandom, STRB_W'($urandom));
    end
    @(negedge clk_i);
    req_valid_i = 1'b0;
    wait_drained();

    // Reset with responses pending, none of them may come out afterwards
    test_name = "mid_reset";
    hold_rsp  = 1'b1;
    send_req(1'b1, CFG_BASE + 32'h4, $urandom, 4'hF);
    send_req(1'b0, rand_l2_addr(), '0, '0);
    send_req(1'b0, rand_err_addr(), '0, '0);
    @(negedge clk_i);
    req_valid_i = 1'b0;
    rst_i       = 1'b1;
    repeat (2) @(negedge clk_i);
    rst_i = 1'b0;
    exp_rdata_q.delete();
    exp_err_q.delete();
    exp_name_q.delete();
    shadow_scratch = '0;
    shadow_rd_cnt  = '0;
    shadow_wr_cnt  = '0;
    hold_rsp       = 1'b0;

    test_name = "after_reset";
    send_req(1'b0, CFG_BASE + 32'h4, '0, '0);
    send_req(1'b0, CFG_BASE + 32'h8, '0, '0);
    send_req(1'b0, CFG_BASE + 32'hC, '0, '0);
    @(negedge clk_i);
    req_valid_i = 1'b0;
    wait_drained();

    if (i_dut.i_props.err_cnt != 0) begin
      report_failure("A protocol assertion on the response port failed");
    end else begin
      $display("All tests passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- flist.f
hdl/host_domain_pkg.sv
hdl/rsp_fifo.sv
hdl/req_decoder.sv
hdl/l2_bank_array.sv
hdl/cfg_regs.sv
hdl/rsp_merger.sv
hdl/host_domain.sv
bench/host_domain_props.sv
bench/tb_host_domain.sv

//--- run.sh
#!/bin/sh
# Builds the host_domain testbench with Verilator and runs it.
# The result is taken from the simulation log.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_host_domain \
  -f flist.f

./obj_dir/Vtb_host_domain | tee sim.log

if grep -q "All tests passed" sim.log; then
  echo "Simulation PASSED"
else
  echo "Simulation FAILED"
  exit 1
fi
